// File: litex_mem_bridge.f
mem_bridge_pkg.sv
core_req_queue.sv
core_arbiter.sv
wishbone_master.sv
wishbone_adapter.sv
litex_mem_wrapper.sv
tb_litex_mem_wrapper.sv

// File: Bender.yml
package:
  name: litex_mem_bridge

sources:
  - mem_bridge_pkg.sv
  - core_req_queue.sv
  - core_arbiter.sv
  - wishbone_master.sv
  - wishbone_adapter.sv
  - litex_mem_wrapper.sv
  - target: test
    files:
      - tb_litex_mem_wrapper.sv

// File: tb_litex_mem_wrapper.sv
`default_nettype none

module tb_litex_mem_wrapper;

    localparam int N = mem_bridge_pkg::NUM_CORES;
    localparam int AW = mem_bridge_pkg::ADDR_W;
    localparam int DW = mem_bridge_pkg::DATA_W;
    localparam int SW = mem_bridge_pkg::SEL_W;
    localparam int NREQ = mem_bridge_pkg::QUEUE_DEPTH + 2;
    localparam int TIMEOUT = 200;

    logic                           clk;
    logic                           rst;
    logic [N-1:0]                   mem_request;
    logic [N-1:0]                   mem_ack;
    mem_bridge_pkg::mem_op_t [N-1:0] mem_op;
    logic [N-1:0][AW-1:0]           mem_addr;
    logic [N-1:0][DW-1:0]           mem_wdata;
    logic [N-1:0][SW-1:0]           mem_be;
    logic [N-1:0]                   resp_valid;
    logic [N-1:0]                   resp_err;
    logic [N-1:0][DW-1:0]           resp_rdata;
    logic [AW-1:0]                  idbus_adr;
    logic [DW-1:0]                  idbus_dat_w;
    logic [SW-1:0]                  idbus_sel;
    logic                           idbus_cyc;
    logic                           idbus_stb;
    logic                           idbus_we;
    logic [DW-1:0]                  idbus_dat_r;
    logic                           idbus_ack;
    logic                           idbus_err;

    // Slave model state
    logic [DW-1:0] slave_mem [256];
    logic          stall;
    int            ack_wait;
    int            wait_cnt;
    logic [AW-1:0] err_addr;

    // Bus cycles as the slave saw them
    logic [AW-1:0] log_adr [$];
    logic [DW-1:0] log_dat [$];
    logic [SW-1:0] log_sel [$];
    logic          log_we [$];

    // Responses in arrival order, tagged with the core
    int            rsp_core [$];
    logic [DW-1:0] rsp_data [$];
    logic          rsp_err [$];

    int          errors;
    int          checks;
    logic [31:0] rng_state;

    litex_mem_wrapper dut0 (
        .clk         (clk),
        .rst         (rst),
        .mem_request (mem_request),
        .mem_ack     (mem_ack),
        .mem_op      (mem_op),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_be      (mem_be),
        .resp_valid  (resp_valid),
        .resp_err    (resp_err),
        .resp_rdata  (resp_rdata),
        .idbus_adr   (idbus_adr),
        .idbus_dat_w (idbus_dat_w),
        .idbus_sel   (idbus_sel),
        .idbus_cyc   (idbus_cyc),
        .idbus_stb   (idbus_stb),
        .idbus_we    (idbus_we),
        .idbus_dat_r (idbus_dat_r),
        .idbus_ack   (idbus_ack),
        .idbus_err   (idbus_err)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // Wishbone slave, answers after ack_wait cycles unless stalled
    always @(posedge clk) begin
        #1;
        idbus_ack = 1'b0;
        idbus_err = 1'b0;
        if (rst || !(idbus_cyc && idbus_stb) || stall) begin
            wait_cnt = 0;
        end else if (wait_cnt < ack_wait) begin
            wait_cnt++;
        end else begin
            wait_cnt = 0;
            log_adr.push_back(idbus_adr);
            log_dat.push_back(idbus_dat_w);
            log_sel.push_back(idbus_sel);
            log_we.push_back(idbus_we);
            if (idbus_adr == err_addr) begin
                idbus_err = 1'b1;
                idbus_dat_r = '0;
            end else begin
                idbus_ack = 1'b1;
                idbus_dat_r = slave_mem[idbus_adr[7:0]];
                if (idbus_we) begin
                    for (int b = 0; b < SW; b++) begin
                        if (idbus_sel[b]) begin
                            slave_mem[idbus_adr[7:0]][8*b +: 8] = idbus_dat_w[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    // Response monitor
    always @(negedge clk) begin
        for (int c = 0; c < N; c++) begin
            if (resp_valid[c]) begin
                rsp_core.push_back(c);
                rsp_data.push_back(resp_rdata[c]);
                rsp_err.push_back(resp_err[c]);
            end
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int find_resp(input int core);
        for (int i = 0; i < rsp_core.size(); i++) begin
            if (rsp_core[i] == core) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_data(input string name, input logic [DW-1:0] got,
                              input logic [DW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [AW-1:0] got,
                              input logic [AW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_sel(input string name, input logic [SW-1:0] got,
                             input logic [SW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_op(input string name, input mem_bridge_pkg::mem_op_t got,
                            input mem_bridge_pkg::mem_op_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic clear_logs();
        log_adr.delete();
        log_dat.delete();
        log_sel.delete();
        log_we.delete();
        rsp_core.delete();
        rsp_data.delete();
        rsp_err.delete();
    endtask

    task automatic set_stall(input logic value);
        @(negedge clk);
        stall = value;
    endtask

    task automatic drive_req(input int core, input mem_bridge_pkg::mem_op_t op,
                             input logic [AW-1:0] addr, input logic [DW-1:0] wdata,
                             input logic [SW-1:0] be);
        @(posedge clk);
        #1;
        mem_request[core] = 1'b1;
        mem_op[core] = op;
        mem_addr[core] = addr;
        mem_wdata[core] = wdata;
        mem_be[core] = be;
    endtask

    task automatic wait_accept(input int core);
        int t;
        t = 0;
        @(negedge clk);
        while (!mem_ack[core] && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!mem_ack[core]) begin
            errors++;
            $display("Timeout: the request on core %0d was never accepted", core);
        end
        @(posedge clk);
        #1;
        mem_request[core] = 1'b0;
    endtask

    task automatic send(input int core, input mem_bridge_pkg::mem_op_t op,
                        input logic [AW-1:0] addr, input logic [DW-1:0] wdata,
                        input logic [SW-1:0] be);
        drive_req(core, op, addr, wdata, be);
        wait_accept(core);
    endtask

    task automatic wait_bus(input int n);
        int t;
        t = 0;
        while (log_adr.size() < n && t < TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        if (log_adr.size() < n) begin
            errors++;
            $display("Timeout: only %0d of %0d bus cycles completed", log_adr.size(), n);
        end
    endtask

    // Takes the oldest response of one core and compares it
    task automatic expect_resp(input int core, input logic exp_err, input logic check_rd,
                               input logic [DW-1:0] exp_data);
        int t;
        int idx;
        t = 0;
        idx = find_resp(core);
        while (idx < 0 && t < TIMEOUT) begin
            @(posedge clk);
            t++;
            idx = find_resp(core);
        end
        if (idx < 0) begin
            errors++;
            $display("Timeout: no response arrived on core %0d", core);
        end else begin
            check_flag($sformatf("resp_err[%0d]", core), rsp_err[idx], exp_err);
            if (check_rd) begin
                check_data($sformatf("resp_rdata[%0d]", core), rsp_data[idx], exp_data);
            end
            rsp_core.delete(idx);
            rsp_data.delete(idx);
            rsp_err.delete(idx);
        end
    endtask

    task automatic check_quiet();
        check_flag("idbus_cyc", idbus_cyc, 1'b0);
        check_flag("idbus_stb", idbus_stb, 1'b0);
        for (int c = 0; c < N; c++) begin
            check_flag($sformatf("mem_ack[%0d]", c), mem_ack[c], 1'b0);
            check_flag($sformatf("resp_valid[%0d]", c), resp_valid[c], 1'b0);
        end
    endtask

    task automatic test_reset();
        rst = 1'b1;
        repeat (5) begin
            @(posedge clk);
            #1;
            check_quiet();
        end
        rst = 1'b0;
        @(negedge clk);
        check_quiet();
    endtask

    task automatic test_write_read();
        logic [AW-1:0] addr;
        logic [DW-1:0] data;
        addr = 30'h15;
        data = next_rand();
        clear_logs();
        ack_wait = 1;
        send(0, mem_bridge_pkg::MEM_WRITE, addr, data, 4'hf);
        expect_resp(0, 1'b0, 1'b0, '0);
        wait_bus(1);
        if (log_adr.size() >= 1) begin
            check_op("idbus_we", mem_bridge_pkg::mem_op_t'(log_we[0]), mem_bridge_pkg::MEM_WRITE);
            check_addr("idbus_adr", log_adr[0], addr);
            check_data("idbus_dat_w", log_dat[0], data);
            check_sel("idbus_sel", log_sel[0], 4'hf);
        end
        send(0, mem_bridge_pkg::MEM_READ, addr, next_rand(), 4'hf);
        expect_resp(0, 1'b0, 1'b1, data);
        wait_bus(2);
        if (log_adr.size() >= 2) begin
            check_op("idbus_we", mem_bridge_pkg::mem_op_t'(log_we[1]), mem_bridge_pkg::MEM_READ);
        end
    endtask

    task automatic test_error();
        clear_logs();
        ack_wait = 0;
        send(1, mem_bridge_pkg::MEM_READ, err_addr, '0, 4'hf);
        expect_resp(1, 1'b1, 1'b0, '0);
        repeat (2) @(posedge clk);
        checks++;
        if (find_resp(0) >= 0) begin
            errors++;
            $display("Core 0 received a response to a core 1 request");
        end
    endtask

    task automatic test_round_robin();
        logic [DW-1:0] exp0 [2];
        logic [DW-1:0] exp1 [2];
        clear_logs();
        ack_wait = 0;
        for (int i = 0; i < 2; i++) begin
            exp0[i] = slave_mem[8'h30 + i];
            exp1[i] = slave_mem[8'h50 + i];
        end
        set_stall(1'b1);
        fork
            begin
                send(0, mem_bridge_pkg::MEM_READ, 30'h30, '0, 4'hf);
                send(0, mem_bridge_pkg::MEM_READ, 30'h31, '0, 4'hf);
            end
            begin
                send(1, mem_bridge_pkg::MEM_READ, 30'h50, '0, 4'hf);
                send(1, mem_bridge_pkg::MEM_READ, 30'h51, '0, 4'hf);
            end
        join
        set_stall(1'b0);
        wait_bus(4);
        // Core 1 owns the 0x5x addresses
        for (int i = 1; i < log_adr.size(); i++) begin
            checks++;
            if ((log_adr[i] >= 30'h40) == (log_adr[i-1] >= 30'h40)) begin
                errors++;
                $display("Bus cycle %0d went to the same core as the one before it", i);
            end
        end
        for (int i = 0; i < 2; i++) begin
            expect_resp(0, 1'b0, 1'b1, exp0[i]);
            expect_resp(1, 1'b0, 1'b1, exp1[i]);
        end
    endtask

    task automatic test_back_pressure();
        logic [DW-1:0] exp [NREQ];
        clear_logs();
        ack_wait = 2;
        for (int i = 0; i < NREQ; i++) begin
            exp[i] = slave_mem[8'h60 + i];
        end
        set_stall(1'b1);
        // One request goes to the master, the rest fill the queue
        for (int i = 0; i < NREQ - 1; i++) begin
            send(0, mem_bridge_pkg::MEM_READ, 30'h60 + AW'(i), '0, 4'hf);
        end
        drive_req(0, mem_bridge_pkg::MEM_READ, 30'h60 + AW'(NREQ - 1), '0, 4'hf);
        repeat (6) begin
            @(negedge clk);
            check_flag("mem_ack[0]", mem_ack[0], 1'b0);
        end
        set_stall(1'b0);
        wait_accept(0);
        for (int i = 0; i < NREQ; i++) begin
            expect_resp(0, 1'b0, 1'b1, exp[i]);
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
        rng_state = 32'hd8f1_3e7c;
        rst = 1'b1;
        mem_request = '0;
        for (int c = 0; c < N; c++) begin
            mem_op[c] = mem_bridge_pkg::MEM_READ;
        end
        mem_addr = '0;
        mem_wdata = '0;
        mem_be = '0;
        idbus_dat_r = '0;
        idbus_ack = 1'b0;
        idbus_err = 1'b0;
        stall = 1'b0;
        ack_wait = 0;
        wait_cnt = 0;
        err_addr = 30'hee;
        for (int i = 0; i < 256; i++) begin
            slave_mem[i] = next_rand();
        end

        test_reset();
        test_write_read();
        test_error();
        test_round_robin();
        test_back_pressure();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: litex_mem_wrapper.sv
`default_nettype none

module litex_mem_wrapper (
    input  wire logic                                                           clk,
    input  wire logic                                                           rst,
    input  wire logic [mem_bridge_pkg::NUM_CORES-1:0]                           mem_request,
    output      logic [mem_bridge_pkg::NUM_CORES-1:0]                           mem_ack,
    input  wire mem_bridge_pkg::mem_op_t [mem_bridge_pkg::NUM_CORES-1:0]        mem_op,
    input  wire logic [mem_bridge_pkg::NUM_CORES-1:0][mem_bridge_pkg::ADDR_W-1:0] mem_addr,
    input  wire logic [mem_bridge_pkg::NUM_CORES-1:0][mem_bridge_pkg::DATA_W-1:0] mem_wdata,
    input  wire logic [mem_bridge_pkg::NUM_CORES-1:0][mem_bridge_pkg::SEL_W-1:0]  mem_be,
    output      logic [mem_bridge_pkg::NUM_CORES-1:0]                           resp_valid,
    output      logic [mem_bridge_pkg::NUM_CORES-1:0]                           resp_err,
    output      logic [mem_bridge_pkg::NUM_CORES-1:0][mem_bridge_pkg::DATA_W-1:0] resp_rdata,
    output      logic [mem_bridge_pkg::ADDR_W-1:0]                              idbus_adr,
    output      logic [mem_bridge_pkg::DATA_W-1:0]                              idbus_dat_w,
    output      logic [mem_bridge_pkg::SEL_W-1:0]                               idbus_sel,
    output      logic                                                           idbus_cyc,
    output      logic                                                           idbus_stb,
    output      logic                                                           idbus_we,
    input  wire logic [mem_bridge_pkg::DATA_W-1:0]                              idbus_dat_r,
    input  wire logic                                                           idbus_ack,
    input  wire logic                                                           idbus_err
);

    // All cores share the single idbus
    wishbone_adapter wb_adapter (
        .clk         (clk),
        .rst         (rst),
        .mem_request (mem_request),
        .mem_ack     (mem_ack),
        .mem_op      (mem_op),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_be      (mem_be),
        .resp_valid  (resp_valid),
        .resp_err    (resp_err),
        .resp_rdata  (resp_rdata),
        .idbus_adr   (idbus_adr),
        .idbus_dat_w (idbus_dat_w),
        .idbus_sel   (idbus_sel),
        .idbus_cyc   (idbus_cyc),
        .idbus_stb   (idbus_stb),
        .idbus_we    (idbus_we),
        .idbus_dat_r (idbus_dat_r),
        .idbus_ack   (idbus_ack),
        .idbus_err   (idbus_err)
    );

endmodule

`default_nettype wire

// File: wishbone_adapter.sv
`default_nettype none

module wishbone_adapter (
    input  wire logic                                                           clk,
    input  wire logic                                                           rst,
    input  wire logic [mem_bridge_pkg::NUM_CORES-1:0]                           mem_request,
    output      logic [mem_bridge_pkg::NUM_CORES-1:0]                           mem_ack,
    input  wire mem_bridge_pkg::mem_op_t [mem_bridge_pkg::NUM_CORES-1:0]        mem_op,
    input  wire logic [mem_bridge_pkg::NUM_CORES-1:0][mem_bridge_pkg::ADDR_W-1:0] mem_addr,
    input  wire logic [mem_bridge_pkg::NUM_CORES-1:0][mem_bridge_pkg::DATA_W-1:0] mem_wdata,
    input  wire logic [mem_bridge_pkg::NUM_CORES-1:0][mem_bridge_pkg::SEL_W-1:0]  mem_be,
    output      logic [mem_bridge_pkg::NUM_CORES-1:0]                           resp_valid,
    output      logic [mem_bridge_pkg::NUM_CORES-1:0]                           resp_err,
    output      logic [mem_bridge_pkg::NUM_CORES-1:0][mem_bridge_pkg::DATA_W-1:0] resp_rdata,
    output      logic [mem_bridge_pkg::ADDR_W-1:0]                              idbus_adr,
    output      logic [mem_bridge_pkg::DATA_W-1:0]                              idbus_dat_w,
    output      logic [mem_bridge_pkg::SEL_W-1:0]                               idbus_sel,
    output      logic                                                           idbus_cyc,
    output      logic                                                           idbus_stb,
    output      logic                                                           idbus_we,
    input  wire logic [mem_bridge_pkg::DATA_W-1:0]                              idbus_dat_r,
    input  wire logic                                                           idbus_ack,
    input  wire logic                                                           idbus_err
);

    localparam int N = mem_bridge_pkg::NUM_CORES;
    localparam int ID_W = mem_bridge_pkg::CORE_ID_W;

    logic [N-1:0]                               q_full;
    logic [N-1:0]                               q_pending;
    mem_bridge_pkg::mem_op_t [N-1:0]            q_head_op;
    logic [N-1:0][mem_bridge_pkg::ADDR_W-1:0]   q_head_addr;
    logic [N-1:0][mem_bridge_pkg::DATA_W-1:0]   q_head_wdata;
    logic [N-1:0][mem_bridge_pkg::SEL_W-1:0]    q_head_be;

    logic                                   grant_valid;
    logic [ID_W-1:0]                        grant_id;
    logic                                   master_idle;
    logic                                   m_done;
    logic                                   m_err;
    logic [mem_bridge_pkg::DATA_W-1:0]      m_rdata;

    // Core whose request is on the bus
    logic [ID_W-1:0] owner_id;

    generate
        for (genvar i = 0; i < N; i++) begin : gen_core_queue
            assign mem_ack[i] = mem_request[i] && !q_full[i];

            core_req_queue queue0 (
                .clk        (clk),
                .rst        (rst),
                .push       (mem_ack[i]),
                .pop        (grant_valid && (grant_id == ID_W'(i))),
                .push_op    (mem_op[i]),
                .push_addr  (mem_addr[i]),
                .push_wdata (mem_wdata[i]),
                .push_be    (mem_be[i]),
                .full       (q_full[i]),
                .pending    (q_pending[i]),
                .head_op    (q_head_op[i]),
                .head_addr  (q_head_addr[i]),
                .head_wdata (q_head_wdata[i]),
                .head_be    (q_head_be[i])
            );

            // Only the owner sees the response
            assign resp_valid[i] = m_done && (owner_id == ID_W'(i));
            assign resp_err[i] = m_done && (owner_id == ID_W'(i)) && m_err;
            assign resp_rdata[i] = m_rdata;
        end
    endgenerate

    core_arbiter arbiter0 (
        .clk         (clk),
        .rst         (rst),
        .pending     (q_pending),
        .master_idle (master_idle),
        .grant_valid (grant_valid),
        .grant_id    (grant_id)
    );

    always_ff @(posedge clk) begin
        if (grant_valid) begin
            owner_id <= grant_id;
        end
    end

    wishbone_master master0 (
        .clk         (clk),
        .rst         (rst),
        .start       (grant_valid),
        .op          (q_head_op[grant_id]),
        .addr        (q_head_addr[grant_id]),
        .wdata       (q_head_wdata[grant_id]),
        .be          (q_head_be[grant_id]),
        .idbus_dat_r (idbus_dat_r),
        .idbus_ack   (idbus_ack),
        .idbus_err   (idbus_err),
        .idle        (master_idle),
        .idbus_adr   (idbus_adr),
        .idbus_dat_w (idbus_dat_w),
        .idbus_sel   (idbus_sel),
        .idbus_cyc   (idbus_cyc),
        .idbus_stb   (idbus_stb),
        .idbus_we    (idbus_we),
        .done        (m_done),
        .err         (m_err),
        .rdata       (m_rdata)
    );

endmodule

`default_nettype wire

// File: wishbone_master.sv
`default_nettype none

module wishbone_master (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               start,
    input  wire mem_bridge_pkg::mem_op_t            op,
    input  wire logic [mem_bridge_pkg::ADDR_W-1:0]  addr,
    input  wire logic [mem_bridge_pkg::DATA_W-1:0]  wdata,
    input  wire logic [mem_bridge_pkg::SEL_W-1:0]   be,
    input  wire logic [mem_bridge_pkg::DATA_W-1:0]  idbus_dat_r,
    input  wire logic                               idbus_ack,
    input  wire logic                               idbus_err,
    output      logic                               idle,
    output      logic [mem_bridge_pkg::ADDR_W-1:0]  idbus_adr,
    output      logic [mem_bridge_pkg::DATA_W-1:0]  idbus_dat_w,
    output      logic [mem_bridge_pkg::SEL_W-1:0]   idbus_sel,
    output      logic                               idbus_cyc,
    output      logic                               idbus_stb,
    output      logic                               idbus_we,
    output      logic                               done,
    output      logic                               err,
    output      logic [mem_bridge_pkg::DATA_W-1:0]  rdata
);

    mem_bridge_pkg::wb_state_t state;

    // Request held for the whole bus cycle
    mem_bridge_pkg::mem_op_t            op_q;
    logic [mem_bridge_pkg::ADDR_W-1:0]  addr_q;
    logic [mem_bridge_pkg::DATA_W-1:0]  wdata_q;
    logic [mem_bridge_pkg::SEL_W-1:0]   be_q;

    logic bus_end;

    assign bus_end = idbus_ack || idbus_err;

    // Response cycle also accepts the next grant
    assign idle = (state != mem_bridge_pkg::WB_CYCLE);
    assign done = (state == mem_bridge_pkg::WB_DONE);

    assign idbus_cyc = (state == mem_bridge_pkg::WB_CYCLE);
    assign idbus_stb = (state == mem_bridge_pkg::WB_CYCLE);
    assign idbus_we = idbus_cyc && (op_q == mem_bridge_pkg::MEM_WRITE);
    assign idbus_adr = addr_q;
    assign idbus_dat_w = wdata_q;
    assign idbus_sel = be_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mem_bridge_pkg::WB_IDLE;
        end else begin
            case (state)
                mem_bridge_pkg::WB_IDLE: begin
                    if (start) begin
                        state <= mem_bridge_pkg::WB_CYCLE;
                    end
                end
                mem_bridge_pkg::WB_CYCLE: begin
                    if (bus_end) begin
                        state <= mem_bridge_pkg::WB_DONE;
                    end
                end
                mem_bridge_pkg::WB_DONE: begin
                    if (start) begin
                        state <= mem_bridge_pkg::WB_CYCLE;
                    end else begin
                        state <= mem_bridge_pkg::WB_IDLE;
                    end
                end
                default: state <= mem_bridge_pkg::WB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && idle) begin
            op_q <= op;
            addr_q <= addr;
            wdata_q <= wdata;
            be_q <= be;
        end
    end

    // Result capture on the terminating cycle
    always_ff @(posedge clk) begin
        if (idbus_cyc && bus_end) begin
            rdata <= idbus_dat_r;
            err <= idbus_err;
        end
    end

    // Classic cycle: request must not move while the slave stalls
    assert property (@(posedge clk) disable iff (rst)
        (idbus_cyc && !bus_end) |=> (idbus_cyc && $stable(idbus_adr) &&
            $stable(idbus_sel) && $stable(idbus_dat_w) && $stable(idbus_we)));

endmodule

`default_nettype wire

// File: core_arbiter.sv
`default_nettype none

module core_arbiter (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  wire logic [mem_bridge_pkg::NUM_CORES-1:0]   pending,
    input  wire logic                                   master_idle,
    output      logic                                   grant_valid,
    output      logic [mem_bridge_pkg::CORE_ID_W-1:0]   grant_id
);

    localparam int N = mem_bridge_pkg::NUM_CORES;
    localparam int ID_W = mem_bridge_pkg::CORE_ID_W;

    // Highest priority core for the next grant
    logic [ID_W-1:0] rr_ptr;

    always_comb begin
        grant_valid = 1'b0;
        grant_id = '0;
        for (int i = 0; i < N; i++) begin
            automatic int idx;
            idx = int'(rr_ptr) + i;
            if (idx >= N) begin
                idx = idx - N;
            end
            if (!grant_valid && master_idle && pending[idx]) begin
                grant_valid = 1'b1;
                grant_id = ID_W'(idx);
            end
        end
    end

    // Winner drops to lowest priority
    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else if (grant_valid) begin
            if (grant_id == ID_W'(N - 1)) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= grant_id + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) grant_valid |-> pending[grant_id]);

endmodule

`default_nettype wire

// File: core_req_queue.sv
`default_nettype none

module core_req_queue (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               push,
    input  wire logic                               pop,
    input  wire mem_bridge_pkg::mem_op_t            push_op,
    input  wire logic [mem_bridge_pkg::ADDR_W-1:0]  push_addr,
    input  wire logic [mem_bridge_pkg::DATA_W-1:0]  push_wdata,
    input  wire logic [mem_bridge_pkg::SEL_W-1:0]   push_be,
    output      logic                               full,
    output      logic                               pending,
    output      mem_bridge_pkg::mem_op_t            head_op,
    output      logic [mem_bridge_pkg::ADDR_W-1:0]  head_addr,
    output      logic [mem_bridge_pkg::DATA_W-1:0]  head_wdata,
    output      logic [mem_bridge_pkg::SEL_W-1:0]   head_be
);

    localparam int PTR_W = mem_bridge_pkg::QUEUE_PTR_W;
    localparam int CNT_W = mem_bridge_pkg::QUEUE_CNT_W;
    localparam int DEPTH = mem_bridge_pkg::QUEUE_DEPTH;

    mem_bridge_pkg::mem_op_t            buf_op    [DEPTH];
    logic [mem_bridge_pkg::ADDR_W-1:0]  buf_addr  [DEPTH];
    logic [mem_bridge_pkg::DATA_W-1:0]  buf_wdata [DEPTH];
    logic [mem_bridge_pkg::SEL_W-1:0]   buf_be    [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign full = (count == CNT_W'(DEPTH));
    assign pending = (count != '0);

    // Oldest entry goes straight to the arbiter side
    assign head_op = buf_op[rd_ptr];
    assign head_addr = buf_addr[rd_ptr];
    assign head_wdata = buf_wdata[rd_ptr];
    assign head_be = buf_be[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buf_op[wr_ptr] <= push_op;
            buf_addr[wr_ptr] <= push_addr;
            buf_wdata[wr_ptr] <= push_wdata;
            buf_be[wr_ptr] <= push_be;
        end
    end

    // Adapter must gate mem_ack with full
    assert property (@(posedge clk) disable iff (rst) full |-> !push);

    // Arbiter only grants a core with something queued
    assert property (@(posedge clk) disable iff (rst) !pending |-> !pop);

endmodule

`default_nettype wire

// File: mem_bridge_pkg.sv
`default_nettype none

package mem_bridge_pkg;

    // Number of core memory ports merged onto idbus
    localparam int NUM_CORES = 2;

    // Wishbone word address, data and byte select widths
    localparam int ADDR_W = 30;
    localparam int DATA_W = 32;
    localparam int SEL_W = 4;

    // Entries held per core before mem_ack drops
    localparam int QUEUE_DEPTH = 2;

    // Derived widths, kept at least one bit wide
    localparam int CORE_ID_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;
    localparam int QUEUE_PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    // Core request type
    typedef enum logic [0:0] {
        MEM_READ = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_t;

    // Bus master FSM
    typedef enum logic [1:0] {
        WB_IDLE = 2'd0,
        WB_CYCLE = 2'd1,
        WB_DONE = 2'd2
    } wb_state_t;

endpackage

`default_nettype wire
